//--- src/cpu_pkg.sv
package cpu_pkg;

	// Datapath and register number widths
	localparam int DATA_W = 32;
	localparam int REG_ADDR_W = 4;
	localparam int OPCODE_W = 5;

	// Instruction opcodes, bits 31:27 of the instruction word
	typedef enum logic [OPCODE_W-1:0] {
		nop    = 5'd0,
		// Register-register, rc = ra op rb
		add    = 5'd1,
		sub    = 5'd2,
		and_op = 5'd3,
		or_op  = 5'd4,
		xor_op = 5'd5,
		shl    = 5'd6,
		shr    = 5'd7,
		// Immediate forms
		addi   = 5'd8,
		ldi    = 5'd9,
		// Data memory
		ld     = 5'd10,
		st     = 5'd11,
		// Unconditional branches
		jmp    = 5'd12,
		br     = 5'd13
	} opcode_t;

	// Width of the sign-extended immediate field
	typedef enum logic [1:0] {
		imm15 = 2'd0,
		imm19 = 2'd1,
		imm27 = 2'd2
	} imm_sel_t;

	// Which register field names the destination
	typedef enum logic [1:0] {
		dst_ra = 2'd0,
		dst_rb = 2'd1,
		dst_rc = 2'd2
	} dst_sel_t;

endpackage

//--- src/register_file.sv
`timescale 1ns/100ps

module register_file (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] rd1_addr,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] rd2_addr,
	input  logic                          wr,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] wr_dst,
	input  logic [cpu_pkg::DATA_W-1:0]     wr_data,
	output logic [cpu_pkg::DATA_W-1:0]     rd1_data,
	output logic [cpu_pkg::DATA_W-1:0]     rd2_data
);

	localparam int NUM_REGS = 2 ** cpu_pkg::REG_ADDR_W;

	logic [cpu_pkg::DATA_W-1:0] regs [NUM_REGS];

	// All registers come out of reset as zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr) begin
			regs[wr_dst] <= wr_data;
		end
	end

	// Plain reads, bypass is handled in decode
	assign rd1_data = regs[rd1_addr];
	assign rd2_data = regs[rd2_addr];

	// A write-back must name a real register
	a_wr_dst_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		wr |-> !$isunknown(wr_dst)
	);

endmodule

//--- src/control_unit.sv
`timescale 1ns/100ps

module control_unit (
	input  cpu_pkg::opcode_t  opcode,
	output cpu_pkg::imm_sel_t imm_sel,
	output cpu_pkg::dst_sel_t dst_sel,
	output logic              branch_sel,
	output logic              branch_rel
);

	always_comb begin
		// Register-register defaults
		imm_sel    = cpu_pkg::imm15;
		dst_sel    = cpu_pkg::dst_rc;
		branch_sel = 1'b0;
		branch_rel = 1'b0;

		case (opcode)
			cpu_pkg::add,
			cpu_pkg::sub,
			cpu_pkg::and_op,
			cpu_pkg::or_op,
			cpu_pkg::xor_op,
			cpu_pkg::shl,
			cpu_pkg::shr: begin
				dst_sel = cpu_pkg::dst_rc;
			end

			// ra + imm15 into rb, also the memory address
			cpu_pkg::addi,
			cpu_pkg::ld,
			cpu_pkg::st: begin
				imm_sel = cpu_pkg::imm15;
				dst_sel = cpu_pkg::dst_rb;
			end

			cpu_pkg::ldi: begin
				imm_sel = cpu_pkg::imm19;
				dst_sel = cpu_pkg::dst_ra;
			end

			// Absolute target
			cpu_pkg::jmp: begin
				imm_sel    = cpu_pkg::imm27;
				branch_sel = 1'b1;
			end

			// Target relative to pc_plus_4
			cpu_pkg::br: begin
				imm_sel    = cpu_pkg::imm27;
				branch_sel = 1'b1;
				branch_rel = 1'b1;
			end

			default: begin
				dst_sel = cpu_pkg::dst_rc;
			end
		endcase
	end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [cpu_pkg::DATA_W-1:0]     instr,
	input  logic [cpu_pkg::DATA_W-1:0]     pc_plus_4,
	input  logic                           wr,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] wr_dst,
	input  logic [cpu_pkg::DATA_W-1:0]     wr_data,
	output logic                           branch_sel,
	output logic [cpu_pkg::DATA_W-1:0]     branch_pc,
	output cpu_pkg::opcode_t               ex_opcode,
	output logic [cpu_pkg::DATA_W-1:0]     ex_a,
	output logic [cpu_pkg::DATA_W-1:0]     ex_b,
	output logic [cpu_pkg::DATA_W-1:0]     ex_imm,
	output logic [cpu_pkg::REG_ADDR_W-1:0] ex_dst
);

	cpu_pkg::opcode_t               opcode;
	cpu_pkg::imm_sel_t              imm_sel;
	cpu_pkg::dst_sel_t              dst_sel;
	logic                           branch_rel;
	logic [cpu_pkg::REG_ADDR_W-1:0] ra, rb, rc, dst;
	logic [cpu_pkg::DATA_W-1:0]     rd1_data, rd2_data, op_a, op_b, imm;

	// Instruction fields
	assign opcode = cpu_pkg::opcode_t'(instr[31:27]);
	assign ra     = instr[26:23];
	assign rb     = instr[22:19];
	assign rc     = instr[18:15];

	register_file rf_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd1_addr (ra),
		.rd2_addr (rb),
		.wr       (wr),
		.wr_dst   (wr_dst),
		.wr_data  (wr_data),
		.rd1_data (rd1_data),
		.rd2_data (rd2_data)
	);

	control_unit ctrl_i (
		.opcode     (opcode),
		.imm_sel    (imm_sel),
		.dst_sel    (dst_sel),
		.branch_sel (branch_sel),
		.branch_rel (branch_rel)
	);

	// Write-back bypass
	assign op_a = (wr && wr_dst == ra) ? wr_data : rd1_data;
	assign op_b = (wr && wr_dst == rb) ? wr_data : rd2_data;

	always_comb begin
		case (imm_sel)
			cpu_pkg::imm19: imm = {{13{instr[18]}}, instr[18:0]};
			cpu_pkg::imm27: imm = {{5{instr[26]}}, instr[26:0]};
			default:        imm = {{17{instr[14]}}, instr[14:0]};
		endcase
		case (dst_sel)
			cpu_pkg::dst_ra: dst = ra;
			cpu_pkg::dst_rb: dst = rb;
			default:         dst = rc;
		endcase
	end

	assign branch_pc = imm + (branch_rel ? pc_plus_4 : '0);

	// ID/EX register with branches passed on as nop
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) ex_opcode <= cpu_pkg::nop;
		else        ex_opcode <= branch_sel ? cpu_pkg::nop : opcode;
	end

	always_ff @(posedge clk) begin
		ex_a   <= op_a;
		ex_b   <= op_b;
		ex_imm <= imm;
		ex_dst <= dst;
	end

	a_branch_is_jump: assert property (
		@(posedge clk) disable iff (!rst_n)
		branch_sel |-> (opcode inside {cpu_pkg::jmp, cpu_pkg::br})
	);

endmodule

//--- src/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
	input  logic                           clk,
	input  logic                           rst_n,
	input  cpu_pkg::opcode_t               ex_opcode,
	input  logic [cpu_pkg::DATA_W-1:0]     ex_a,
	input  logic [cpu_pkg::DATA_W-1:0]     ex_b,
	input  logic [cpu_pkg::DATA_W-1:0]     ex_imm,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_dst,
	output cpu_pkg::opcode_t               res_opcode,
	output logic [cpu_pkg::DATA_W-1:0]     res_value,
	output logic [cpu_pkg::DATA_W-1:0]     res_store_data,
	output logic [cpu_pkg::REG_ADDR_W-1:0] res_dst
);

	logic [cpu_pkg::DATA_W-1:0] alu_out;
	logic [4:0]                 shamt;

	// Only the low five bits of rb count as a shift amount
	assign shamt = ex_b[4:0];

	always_comb begin
		case (ex_opcode)
			cpu_pkg::add: begin
				alu_out = ex_a + ex_b;
			end
			cpu_pkg::sub: begin
				alu_out = ex_a - ex_b;
			end
			cpu_pkg::and_op: begin
				alu_out = ex_a & ex_b;
			end
			cpu_pkg::or_op: begin
				alu_out = ex_a | ex_b;
			end
			cpu_pkg::xor_op: begin
				alu_out = ex_a ^ ex_b;
			end
			cpu_pkg::shl: begin
				alu_out = ex_a << shamt;
			end
			// Logical, zero fill
			cpu_pkg::shr: begin
				alu_out = ex_a >> shamt;
			end
			// Sum or word address
			cpu_pkg::addi,
			cpu_pkg::ld,
			cpu_pkg::st: begin
				alu_out = ex_a + ex_imm;
			end
			cpu_pkg::ldi: begin
				alu_out = ex_imm;
			end
			default: begin
				alu_out = '0;
			end
		endcase
	end

	// EX/RES
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) res_opcode <= cpu_pkg::nop;
		else        res_opcode <= ex_opcode;
	end

	always_ff @(posedge clk) begin
		res_value      <= alu_out;
		res_store_data <= ex_b;
		res_dst        <= ex_dst;
	end

endmodule

//--- src/result_stage.sv
`timescale 1ns/100ps

module result_stage #(
	parameter int DMEM_WORDS = 64
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  cpu_pkg::opcode_t               res_opcode,
	input  logic [cpu_pkg::DATA_W-1:0]     res_value,
	input  logic [cpu_pkg::DATA_W-1:0]     res_store_data,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] res_dst,
	output logic                           wr,
	output logic [cpu_pkg::REG_ADDR_W-1:0] wr_dst,
	output logic [cpu_pkg::DATA_W-1:0]     wr_data
);

	localparam int IDX_W = $clog2(DMEM_WORDS);

	logic [cpu_pkg::DATA_W-1:0] mem [DMEM_WORDS];
	logic [IDX_W-1:0]           mem_idx;
	logic                       wb_en;

	// Word index wraps at the memory depth
	assign mem_idx = IDX_W'(res_value % DMEM_WORDS);

	// Memory starts out cleared
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (res_opcode == cpu_pkg::st) begin
			mem[mem_idx] <= res_store_data;
		end
	end

	// Everything that names a destination writes back
	always_comb begin
		case (res_opcode)
			cpu_pkg::add, cpu_pkg::sub, cpu_pkg::and_op, cpu_pkg::or_op,
			cpu_pkg::xor_op, cpu_pkg::shl, cpu_pkg::shr,
			cpu_pkg::addi, cpu_pkg::ldi, cpu_pkg::ld: wb_en = 1'b1;
			default:                                  wb_en = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) wr <= 1'b0;
		else        wr <= wb_en;
	end

	always_ff @(posedge clk) begin
		wr_dst  <= res_dst;
		wr_data <= (res_opcode == cpu_pkg::ld) ? mem[mem_idx] : res_value;
	end

	a_no_wb_on_st_nop: assert property (
		@(posedge clk) disable iff (!rst_n)
		(res_opcode inside {cpu_pkg::nop, cpu_pkg::st}) |=> !wr
	);

endmodule

//--- src/cpu_core.sv
`timescale 1ns/100ps

module cpu_core #(
	parameter int DMEM_WORDS = 64
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [cpu_pkg::DATA_W-1:0]     instr,
	input  logic [cpu_pkg::DATA_W-1:0]     pc_plus_4,
	output logic                           branch_sel,
	output logic [cpu_pkg::DATA_W-1:0]     branch_pc,
	output logic                           wr,
	output logic [cpu_pkg::REG_ADDR_W-1:0] wr_dst,
	output logic [cpu_pkg::DATA_W-1:0]     wr_data
);

	// ID/EX
	cpu_pkg::opcode_t               ex_opcode;
	logic [cpu_pkg::DATA_W-1:0]     ex_a, ex_b, ex_imm;
	logic [cpu_pkg::REG_ADDR_W-1:0] ex_dst;

	// EX/RES
	cpu_pkg::opcode_t               res_opcode;
	logic [cpu_pkg::DATA_W-1:0]     res_value, res_store_data;
	logic [cpu_pkg::REG_ADDR_W-1:0] res_dst;

	decode_stage decode_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr      (instr),
		.pc_plus_4  (pc_plus_4),
		.wr         (wr),
		.wr_dst     (wr_dst),
		.wr_data    (wr_data),
		.branch_sel (branch_sel),
		.branch_pc  (branch_pc),
		.ex_opcode  (ex_opcode),
		.ex_a       (ex_a),
		.ex_b       (ex_b),
		.ex_imm     (ex_imm),
		.ex_dst     (ex_dst)
	);

	execute_stage execute_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.ex_opcode      (ex_opcode),
		.ex_a           (ex_a),
		.ex_b           (ex_b),
		.ex_imm         (ex_imm),
		.ex_dst         (ex_dst),
		.res_opcode     (res_opcode),
		.res_value      (res_value),
		.res_store_data (res_store_data),
		.res_dst        (res_dst)
	);

	// Write-back loops back into decode
	result_stage #(
		.DMEM_WORDS (DMEM_WORDS)
	) result_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.res_opcode     (res_opcode),
		.res_value      (res_value),
		.res_store_data (res_store_data),
		.res_dst        (res_dst),
		.wr             (wr),
		.wr_dst         (wr_dst),
		.wr_data        (wr_data)
	);

endmodule

//--- bench/cpu_core_tb.sv
`timescale 1ns/100ps

module cpu_core_tb;

	localparam int DMEM_WORDS = 64;
	localparam int RESET_CYCLES = 4;
	localparam int TIMEOUT_CYCLES = 20;
	localparam int SETTLE_NS = 10;

	// One pending write-back and the cycle it is due
	typedef struct packed {
		int unsigned due;
		logic        wr;
		logic [3:0]  dst;
		logic [31:0] data;
	} wb_exp_t;

	logic        clk;
	logic        rst_n;
	logic [31:0] instr;
	logic [31:0] pc_plus_4;
	logic        branch_sel;
	logic [31:0] branch_pc;
	logic        wr;
	logic [3:0]  wr_dst;
	logic [31:0] wr_data;

	wb_exp_t     exp_q[$];
	string       name_q[$];
	string       test_name;
	int unsigned cycle;
	int          errors;
	int          timeouts;
	logic [31:0] lcg_state;

	cpu_core #(
		.DMEM_WORDS (DMEM_WORDS)
	) dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr      (instr),
		.pc_plus_4  (pc_plus_4),
		.branch_sel (branch_sel),
		.branch_pc  (branch_pc),
		.wr         (wr),
		.wr_dst     (wr_dst),
		.wr_data    (wr_data)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic report_mismatch(input string name, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		$display("[ERROR] %s %s: expected %h, actual %h", name, what, expected, actual);
		errors++;
	endtask

	// Step to the falling edge and compare the write-back port with what is due
	task automatic next_cycle();
		wb_exp_t e;
		string   name;
		e = '0;
		name = test_name;
		@(negedge clk);
		cycle++;
		if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
			e = exp_q.pop_front();
			name = name_q.pop_front();
		end
		if (wr !== e.wr) report_mismatch(name, "wr", 32'(e.wr), 32'(wr));
		if (e.wr && wr_dst !== e.dst) report_mismatch(name, "wr_dst", 32'(e.dst), 32'(wr_dst));
		if (e.wr && wr_data !== e.data) report_mismatch(name, "wr_data", e.data, wr_data);
	endtask

	task automatic hold_reset();
		int n;
		for (n = 0; n < RESET_CYCLES; n++) begin
			next_cycle();
		end
		rst_n = 1'b1;
		n = 0;
		while (wr !== 1'b0 && n < TIMEOUT_CYCLES) begin
			next_cycle();
			n++;
		end
		if (n >= TIMEOUT_CYCLES) begin
			$display("timeout: write-back port did not settle after reset release");
			timeouts++;
		end
	endtask

	task automatic run_trace();
		int          fd;
		int          n_read;
		int          gaps;
		int          gap_len;
		string       line;
		string       name;
		logic [31:0] f_instr, f_pc, f_bpc, f_data;
		logic        f_bsel, f_wr;
		logic [3:0]  f_dst;
		gaps = 0;
		fd = $fopen("bench/cpu_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file bench/cpu_trace.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			n_read = $fgets(line, fd);
			if (n_read > 0 && $sscanf(line, "test %s %d", name, gaps) == 2) begin
				test_name = name;
			end else if (n_read > 0 && $sscanf(line, "%h %h %h %h %h %h %h", f_instr, f_pc,
					f_bsel, f_bpc, f_wr, f_dst, f_data) == 7) begin
				if (gaps != 0) begin
					lcg_state = lcg_step(lcg_state);
					gap_len = int'((lcg_state >> 16) % 3);
					for (int g = 0; g < gap_len; g++) begin
						next_cycle();
						instr = '0;
					end
				end
				next_cycle();
				instr = f_instr;
				pc_plus_4 = f_pc;
				exp_q.push_back('{due: cycle + 3, wr: f_wr, dst: f_dst, data: f_data});
				name_q.push_back(test_name);
				// Branch outputs follow instr within the same cycle
				#SETTLE_NS;
				if (branch_sel !== f_bsel) begin
					report_mismatch(test_name, "branch_sel", 32'(f_bsel), 32'(branch_sel));
				end
				if (f_bsel && branch_pc !== f_bpc) begin
					report_mismatch(test_name, "branch_pc", f_bpc, branch_pc);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < TIMEOUT_CYCLES) begin
			next_cycle();
			instr = '0;
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d write-back results never arrived", exp_q.size());
			timeouts++;
		end
	endtask

	initial begin
		instr = '0;
		pc_plus_4 = '0;
		rst_n = 1'b0;
		cycle = 0;
		errors = 0;
		timeouts = 0;
		lcg_state = 32'h588c;
		test_name = "reset";
		hold_reset();
		if (timeouts == 0) run_trace();
		if (timeouts == 0) drain();
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- compile.f
src/cpu_pkg.sv
src/register_file.sv
src/control_unit.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/cpu_core.sv
bench/cpu_core_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = cpu_core_tb
FILELIST = compile.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

//--- bench/cpu_trace.txt
// instr pc_plus_4 branch_sel branch_pc wr wr_dst wr_data, all hex
// A line "test <name> <gaps>" starts a group, gaps 1 allows random nop cycles
test reset_zero 1
080C0000 00000004 0 00000000 1 8 00000000
091C8000 00000008 0 00000000 1 9 00000000
0A2D0000 0000000C 0 00000000 1 a 00000000
0B3D8000 00000010 0 00000000 1 b 00000000
0C4E0000 00000014 0 00000000 1 c 00000000
0D5E8000 00000018 0 00000000 1 d 00000000
0E6F0000 0000001C 0 00000000 1 e 00000000
0F7F8000 00000020 0 00000000 1 f 00000000
test ldi_addi 1
48812345 00000024 0 00000000 1 1 00012345
4907FFFB 00000028 0 00000000 1 2 FFFFFFFB
49840000 0000002C 0 00000000 1 3 FFFC0000
40A07FFF 00000030 0 00000000 1 4 00012344
41280010 00000034 0 00000000 1 5 0000000B
test alu_ops 1
08930000 00000038 0 00000000 1 6 00012340
109B8000 0000003C 0 00000000 1 7 00052345
191C0000 00000040 0 00000000 1 8 FFFC0000
20A48000 00000044 0 00000000 1 9 00012345
28950000 00000048 0 00000000 1 a FFFEDCBE
30AD8000 0000004C 0 00000000 1 b 091A2800
39960000 00000050 0 00000000 1 c 0000001F
test mem_wrap 1
58B00003 00000054 0 00000000 0 0 00000000
50680048 00000058 0 00000000 1 d 00012340
00000000 0000005C 0 00000000 0 0 00000000
test branch 1
60000100 00000060 1 00000100 0 0 00000000
6FFFFFF8 00000064 1 0000005C 0 0 00000000
test stale_read 0
4F000077 00000068 0 00000000 1 e 00000077
0F078000 0000006C 0 00000000 1 f 00000000
08768000 00000070 0 00000000 1 d 00000000
0F760000 00000074 0 00000000 1 c 000000EE
0F058000 00000078 0 00000000 1 b 00000077
